// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_memory_bus_system \
	-o sim_tb_memory_bus_system

output=$(./obj_dir/sim_tb_memory_bus_system)
echo "$output"

grep -q "STATUS: PASS" <<< "$output"

// File: src.f
+incdir+verification
src/mem_bus_pkg.sv
src/bus_router.sv
src/ddram_read_latch.sv
src/io_bridge.sv
src/memory_bus_system.sv
verification/tb_memory_bus_system.sv

// File: src/bus_router.sv
// Bus router
// Region decode, ROM download steering onto DDRAM, video strobe
// Ready merge and read data return to the cpu

`timescale 1ns/10ps

module bus_router (
	input  mem_bus_pkg::cpu_req_t                 cpu_req,
	input  mem_bus_pkg::rom_write_t               rom_write,

	input  logic                                  ddram_ack,
	input  logic                                  ddram_done,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    ddram_data,

	input  logic                                  io_active,
	input  logic                                  io_done,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    io_data,

	input  logic                                  video_ack,

	output mem_bus_pkg::ddram_req_t               ddram_req,
	output logic                                  rom_ack,
	output logic                                  io_select,
	output mem_bus_pkg::video_write_t             video_write,
	output logic                                  cpu_ready,
	output logic [mem_bus_pkg::DATA_WIDTH-1:0]    cpu_rdata
);

	import mem_bus_pkg::*;

	mem_region_e   region;
	logic          cpu_write;

	////////////////////
	// Region decode
	////////////////////

	// Download takes the DDRAM port, all other selects drop
	always_comb begin
		if (rom_write.active) begin
			region = REGION_DDRAM;
		end else begin
			region = mem_region_e'(cpu_req.addr[REGION_MSB:REGION_LSB]);
		end
	end

	assign cpu_write = |cpu_req.wstrb;             // Any lane set means write
	assign io_select = (region == REGION_IO);

	////////////////////
	// DDRAM port
	////////////////////

	always_comb begin
		ddram_req = '0;                               // Idle unless DDRAM selected
		if (region == REGION_DDRAM) begin
			if (rom_write.active) begin
				// Loader writes go straight through
				ddram_req.addr     = rom_write.addr;
				ddram_req.wdata    = rom_write.data;
				ddram_req.byte_sel = '1;             // Whole words
				ddram_req.req      = rom_write.write;
				ddram_req.rw       = 1'b1;
			end else begin
				ddram_req.addr     = cpu_req.addr[DDRAM_ADDR_WIDTH+1:2];
				ddram_req.wdata    = cpu_req.wdata;
				ddram_req.byte_sel = cpu_req.wstrb;
				ddram_req.req      = cpu_req.valid;
				ddram_req.rw       = cpu_write;
			end
		end
	end

	assign rom_ack = ddram_ack;                      // Loader sees DDRAM ack directly

	////////////////////
	// Video strobe
	////////////////////

	always_comb begin
		video_write = '0;
		if (region == REGION_VIDEO) begin
			video_write.addr = cpu_req.addr[VIDEO_ADDR_WIDTH+1:2];
		end
		video_write.data  = cpu_req.wdata;           // Only meaningful with write
		// Reads from video space get no strobe
		video_write.write = (region == REGION_VIDEO) && cpu_req.valid && cpu_write;
	end

	////////////////////
	// Return to cpu
	////////////////////

	// Video ack passes with no added cycle
	assign cpu_ready = ddram_done | io_done | video_ack;

	// IO wins while its access is open
	always_comb begin
		if (io_active) begin
			cpu_rdata = io_data;
		end else if (ddram_done) begin
			cpu_rdata = ddram_data;
		end else begin
			cpu_rdata = '0;
		end
	end

endmodule

// File: src/ddram_read_latch.sv
// DDRAM read latch
// Captures read data on the DDRAM ack and holds completion until valid drops

`timescale 1ns/10ps

module ddram_read_latch (
	input  logic                                  system_clock,
	input  logic                                  system_reset,
	input  logic                                  cpu_valid,
	input  logic                                  ddram_ack,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    ddram_rdata,
	output logic                                  ddram_done,
	output logic [mem_bus_pkg::DATA_WIDTH-1:0]    ddram_data
);

	// Completion flag, two states: waiting or holding
	always_ff @(posedge system_clock) begin
		if (system_reset) begin
			ddram_done <= 1'b0;
		end else if (!ddram_done) begin
			if (cpu_valid && ddram_ack) begin
				ddram_done <= 1'b1;                  // Ready one cycle after ack
			end
		end else if (!cpu_valid) begin
			ddram_done <= 1'b0;                      // Cpu took it
		end
	end

	// Data word, loaded with the ack
	always_ff @(posedge system_clock) begin
		if (!ddram_done && cpu_valid && ddram_ack) begin
			ddram_data <= ddram_rdata;
		end
	end

endmodule

// File: src/io_bridge.sv
// IO bridge
// Registers an IO request, waits for the IO ack, holds the response

`timescale 1ns/10ps

module io_bridge (
	input  logic                                  system_clock,
	input  logic                                  system_reset,
	input  mem_bus_pkg::cpu_req_t                 cpu_req,
	input  logic                                  io_select,
	input  logic                                  io_ack,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    io_rdata,
	output mem_bus_pkg::io_req_t                  io_req,
	output logic                                  io_active,
	output logic                                  io_done,
	output logic [mem_bus_pkg::DATA_WIDTH-1:0]    io_data
);

	import mem_bus_pkg::*;

	io_req_t   next_req;
	logic      start;                               // New IO access seen
	logic      respond;                             // Ack arrives, take the data

	// IO word address and write flag from the cpu request
	always_comb begin
		next_req.addr     = cpu_req.addr[IO_ADDR_WIDTH+1:2];
		next_req.wdata    = cpu_req.wdata;
		next_req.byte_sel = cpu_req.wstrb;
		next_req.write    = |cpu_req.wstrb;
	end

	assign start   = cpu_req.valid && !io_active && io_select;
	assign respond = cpu_req.valid && io_active && !io_done && io_ack;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge system_clock) begin
		if (system_reset) begin
			io_active <= 1'b0;
			io_done   <= 1'b0;
		end else if (!cpu_req.valid) begin
			io_active <= 1'b0;                       // Both drop after valid falls
			io_done   <= 1'b0;
		end else begin
			if (start) begin
				io_active <= 1'b1;                   // Request level to controller
			end
			if (respond) begin
				io_done <= 1'b1;
			end
		end
	end

	////////////////////
	// Payload
	////////////////////

	always_ff @(posedge system_clock) begin
		if (start) begin
			io_req <= next_req;                      // Held for the whole access
		end
		if (respond) begin
			io_data <= io_rdata;
		end
	end

endmodule

// File: src/mem_bus_pkg.sv
// Memory bus package
// Region encoding, address field positions, bus widths
// Packed request structs for processor, DDRAM, IO, video and ROM download

package mem_bus_pkg;

	////////////////////
	// Address map
	////////////////////

	localparam int REGION_MSB = 31;             // Top two address bits pick the region
	localparam int REGION_LSB = 30;

	localparam int DDRAM_ADDR_WIDTH = 27;       // Word address, cpu bits 28:2
	localparam int IO_ADDR_WIDTH    = 28;       // Word address, cpu bits 29:2
	localparam int VIDEO_ADDR_WIDTH = 27;       // Word address, cpu bits 28:2

	localparam int DATA_WIDTH   = 32;
	localparam int STROBE_WIDTH = 4;            // One per byte lane

	// Region decoded from addr[31:30]
	typedef enum logic [1:0] {
		REGION_DDRAM = 2'b00,
		REGION_SDRAM = 2'b01,                   // Decoded, nothing answers
		REGION_IO    = 2'b10,
		REGION_VIDEO = 2'b11
	} mem_region_e;

	////////////////////
	// Bus structs
	////////////////////

	// Processor memory port, picorv32 style
	typedef struct packed {
		logic                          valid;
		logic [31:0]                   addr;    // Byte address
		logic [DATA_WIDTH-1:0]         wdata;
		logic [STROBE_WIDTH-1:0]       wstrb;   // All zero means read
	} cpu_req_t;

	// DDRAM port
	typedef struct packed {
		logic [DDRAM_ADDR_WIDTH-1:0]   addr;
		logic [DATA_WIDTH-1:0]         wdata;
		logic [STROBE_WIDTH-1:0]       byte_sel;
		logic                          req;
		logic                          rw;      // High for write
	} ddram_req_t;

	// IO controller request, registered
	typedef struct packed {
		logic [IO_ADDR_WIDTH-1:0]      addr;
		logic [DATA_WIDTH-1:0]         wdata;
		logic [STROBE_WIDTH-1:0]       byte_sel;
		logic                          write;
	} io_req_t;

	// Video memory write strobe
	typedef struct packed {
		logic [VIDEO_ADDR_WIDTH-1:0]   addr;
		logic [DATA_WIDTH-1:0]         data;
		logic                          write;
	} video_write_t;

	// ROM download from the loader
	typedef struct packed {
		logic                          active;  // Download in progress, owns DDRAM
		logic [DDRAM_ADDR_WIDTH-1:0]   addr;
		logic [DATA_WIDTH-1:0]         data;
		logic                          write;
	} rom_write_t;

endpackage

// File: src/memory_bus_system.sv
// Memory bus fabric top level
// Router, DDRAM read latch and IO bridge between the cpu port and responders

`timescale 1ns/10ps

module memory_bus_system (
	input  logic                                  system_clock,
	input  logic                                  system_reset,

	// Processor port
	input  mem_bus_pkg::cpu_req_t                 cpu_req,
	output logic                                  cpu_ready,
	output logic [mem_bus_pkg::DATA_WIDTH-1:0]    cpu_rdata,

	// ROM loader
	input  mem_bus_pkg::rom_write_t               rom_write,
	output logic                                  rom_ack,

	// DDRAM
	output mem_bus_pkg::ddram_req_t               ddram_req,
	input  logic                                  ddram_ack,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    ddram_rdata,

	// IO controller
	output mem_bus_pkg::io_req_t                  io_req,
	output logic                                  io_active,
	input  logic                                  io_ack,
	input  logic [mem_bus_pkg::DATA_WIDTH-1:0]    io_rdata,

	// Video memory
	output mem_bus_pkg::video_write_t             video_write,
	input  logic                                  video_ack
);

	import mem_bus_pkg::*;

	logic                    ddram_done;    // Latched DDRAM completion
	logic [DATA_WIDTH-1:0]   ddram_data;
	logic                    io_select;     // Current access decodes to IO
	logic                    io_done;
	logic [DATA_WIDTH-1:0]   io_data;

	////////////////////
	// Decode and return
	////////////////////

	bus_router router (
		.cpu_req     (cpu_req),
		.rom_write   (rom_write),
		.ddram_ack   (ddram_ack),
		.ddram_done  (ddram_done),
		.ddram_data  (ddram_data),
		.io_active   (io_active),
		.io_done     (io_done),
		.io_data     (io_data),
		.video_ack   (video_ack),
		.ddram_req   (ddram_req),
		.rom_ack     (rom_ack),
		.io_select   (io_select),
		.video_write (video_write),
		.cpu_ready   (cpu_ready),
		.cpu_rdata   (cpu_rdata)
	);

	// DDRAM read data held for the cpu
	ddram_read_latch ddram_latch (
		.system_clock (system_clock),
		.system_reset (system_reset),
		.cpu_valid    (cpu_req.valid),
		.ddram_ack    (ddram_ack),
		.ddram_rdata  (ddram_rdata),
		.ddram_done   (ddram_done),
		.ddram_data   (ddram_data)
	);

	// IO request register and response hold
	io_bridge io (
		.system_clock (system_clock),
		.system_reset (system_reset),
		.cpu_req      (cpu_req),
		.io_select    (io_select),
		.io_ack       (io_ack),
		.io_rdata     (io_rdata),
		.io_req       (io_req),
		.io_active    (io_active),
		.io_done      (io_done),
		.io_data      (io_data)
	);

endmodule

// File: verification/bus_responders.svh
// Responder models for the DDRAM and IO controller
// Expected address fields and read data fill patterns

logic [31:0] ddram_mem [logic [26:0]];   // DDRAM word store
logic [31:0] io_regs [logic [27:0]];     // IO register file

// Byte lane merge of a write into a stored word
function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] lanes);
	logic [31:0] result;
	result = old_word;
	for (int i = 0; i < 4; i++) begin
		if (lanes[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
	end
	return result;
endfunction

// Unwritten words give an address based pattern
function automatic logic [31:0] ddram_read(input logic [26:0] word_addr);
	if (ddram_mem.exists(word_addr)) return ddram_mem[word_addr];
	return {5'b0, word_addr} ^ 32'hA5A5_5A5A;
endfunction

function automatic void ddram_write(input logic [26:0] word_addr,
		input logic [31:0] data, input logic [3:0] lanes);
	ddram_mem[word_addr] = merge_bytes(ddram_read(word_addr), data, lanes);
endfunction

function automatic logic [31:0] io_read(input logic [27:0] word_addr);
	if (io_regs.exists(word_addr)) return io_regs[word_addr];
	return ~{4'b0, word_addr};            // Reset value of a register
endfunction

function automatic void io_write(input logic [27:0] word_addr,
		input logic [31:0] data, input logic [3:0] lanes);
	io_regs[word_addr] = merge_bytes(io_read(word_addr), data, lanes);
endfunction

// Acknowledge delay, 0 to 5 cycles
function automatic int ack_delay();
	return int'($urandom % 6);
endfunction

// File: verification/tb_memory_bus_system.sv
// Testbench for the memory bus fabric
// Seeded random cpu traffic against DDRAM, IO and video models

`timescale 1ns/10ps

module tb_memory_bus_system;
	import mem_bus_pkg::*;

	logic system_clock, system_reset;
	cpu_req_t cpu_req;
	rom_write_t rom_write;
	logic cpu_ready, rom_ack, ddram_ack, io_ack, video_ack, io_active;
	logic [31:0] cpu_rdata, ddram_rdata, io_rdata;
	ddram_req_t ddram_req;
	io_req_t io_req;
	video_write_t video_write;
	int errors;

	`include "bus_responders.svh"

	memory_bus_system DUT (.*);

	always #10 system_clock = ~system_clock;   // 20 ns period

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Only the decoded region may show a request
	task automatic check_exclusive(input logic [1:0] region);
		if (region != 2'b00 && ddram_req.req) begin
			errors++;
			$display("DDRAM request active during another region's access at %0t", $time);
		end
		if (region != 2'b10 && io_active) begin
			errors++;
			$display("IO request active during another region's access at %0t", $time);
		end
		if (region != 2'b11 && video_write.write) begin
			errors++;
			$display("Video strobe active during another region's access at %0t", $time);
		end
	endtask

	// Drops acks on each falling edge until ready, with timeout
	task automatic wait_ready(output int cycles);
		cycles = 0;
		do begin
			@(negedge system_clock);
			ddram_ack = 1'b0;
			io_ack    = 1'b0;
			cycles++;
		end while (!cpu_ready && cycles < 10);
		if (!cpu_ready) begin
			$display("Timeout waiting for cpu_ready at %0t", $time);
			$display("STATUS: FAIL");
			$finish;
		end
	endtask

	// Holds ready one cycle, then drops valid
	task automatic finish_access(input logic [1:0] region);
		@(negedge system_clock);
		compare_value("cpu_ready held", 32'(cpu_ready), 32'd1);
		check_exclusive(region);                     // Registered IO request has settled
		cpu_req.valid = 1'b0;
		cpu_req.wstrb = '0;
		video_ack     = 1'b0;
		@(negedge system_clock);
		compare_value("cpu_ready", 32'(cpu_ready), 32'd0);
		compare_value("io_active", 32'(io_active), 32'd0);
	endtask

	task automatic cpu_access(input logic [1:0] region, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] wstrb);
		int delay;
		int cycles;
		logic wr;
		logic [31:0] exp;
		wr = |wstrb;
		delay = ack_delay();
		cpu_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
		#1;
		check_exclusive(region);
		if (region == 2'b00) begin
			compare_value("ddram_req.addr", 32'(ddram_req.addr), 32'(addr[28:2]));
			compare_value("ddram_req.byte_sel", 32'(ddram_req.byte_sel), 32'(wstrb));
			compare_value("ddram_req.rw", 32'(ddram_req.rw), 32'(wr));
			compare_value("ddram_req.req", 32'(ddram_req.req), 32'd1);
			if (wr) compare_value("ddram_req.wdata", ddram_req.wdata, wdata);
			repeat (delay) @(negedge system_clock);
			exp = ddram_read(addr[28:2]);
			if (wr) ddram_write(addr[28:2], wdata, wstrb);
			ddram_rdata = wr ? $urandom : exp;
			ddram_ack   = 1'b1;
			wait_ready(cycles);
			compare_value("ddram ack to ready cycles", 32'(cycles), 32'd1);
			if (!wr) compare_value("cpu_rdata", cpu_rdata, exp);
			finish_access(region);
		end else if (region == 2'b10) begin
			compare_value("io_active", 32'(io_active), 32'd0);
			@(negedge system_clock);
			compare_value("io_active", 32'(io_active), 32'd1);   // One cycle after request
			compare_value("io_req.addr", 32'(io_req.addr), 32'(addr[29:2]));
			compare_value("io_req.byte_sel", 32'(io_req.byte_sel), 32'(wstrb));
			compare_value("io_req.write", 32'(io_req.write), 32'(wr));
			if (wr) compare_value("io_req.wdata", io_req.wdata, wdata);
			check_exclusive(region);
			repeat (delay) @(negedge system_clock);
			exp = io_read(addr[29:2]);
			if (wr) io_write(addr[29:2], wdata, wstrb);
			io_rdata = exp;
			io_ack   = 1'b1;
			wait_ready(cycles);
			compare_value("io ack to ready cycles", 32'(cycles), 32'd1);
			compare_value("cpu_rdata", cpu_rdata, io_rdata);
			finish_access(region);
		end else begin
			compare_value("video_write.write", 32'(video_write.write), 32'(wr));
			compare_value("video_write.addr", 32'(video_write.addr), 32'(addr[28:2]));
			if (wr) compare_value("video_write.data", video_write.data, wdata);
			repeat (delay) begin
				@(negedge system_clock);
				compare_value("cpu_ready", 32'(cpu_ready), 32'd0);
			end
			video_ack = 1'b1;
			#1;
			compare_value("cpu_ready", 32'(cpu_ready), 32'd1);    // Same cycle as ack
			finish_access(region);
		end
	endtask

	// Loader writes steered straight onto the DDRAM port
	// Cpu keeps an IO or video write pending that the download holds off
	task automatic rom_download(input int count);
		logic [31:0] tmp;
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			tmp = $urandom;
			rnd = $urandom;
			rom_write = '{active: 1'b1, addr: tmp[26:0], data: $urandom,
				write: tmp[31]};
			cpu_req = '{valid: 1'b1, addr: {1'b1, rnd[30:0]}, wdata: $urandom,
				wstrb: 4'hf};
			ddram_ack = tmp[30];
			#1;
			compare_value("ddram_req.addr", 32'(ddram_req.addr), 32'(tmp[26:0]));
			compare_value("ddram_req.wdata", ddram_req.wdata, rom_write.data);
			compare_value("ddram_req.byte_sel", 32'(ddram_req.byte_sel), 32'hf);
			compare_value("ddram_req.rw", 32'(ddram_req.rw), 32'd1);
			compare_value("ddram_req.req", 32'(ddram_req.req), 32'(tmp[31]));
			compare_value("rom_ack", 32'(rom_ack), 32'(tmp[30]));
			check_exclusive(2'b00);
			if (tmp[31]) ddram_write(tmp[26:0], rom_write.data, 4'hf);
			@(negedge system_clock);
		end
		rom_write = '0;
		ddram_ack = 1'b0;
		cpu_req   = '0;
		@(negedge system_clock);                     // Latch drops its stale completion
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] rnd;
		logic [1:0] region;
		errors = 0;
		void'($urandom(95521));
		system_clock = 1'b0;
		system_reset = 1'b1;
		cpu_req = '0;
		rom_write = '0;
		{ddram_ack, io_ack, video_ack} = '0;
		ddram_rdata = '0;
		io_rdata = '0;
		repeat (3) @(negedge system_clock);
		system_reset = 1'b0;
		@(negedge system_clock);
		compare_value("cpu_ready", 32'(cpu_ready), 32'd0);
		compare_value("io_active", 32'(io_active), 32'd0);
		compare_value("ddram_req.req", 32'(ddram_req.req), 32'd0);
		compare_value("video_write.write", 32'(video_write.write), 32'd0);

		rom_download(20);
		// DDRAM write, then read back the same word
		rnd = $urandom;
		addr = {2'b00, rnd[29:2], 2'b00};
		cpu_access(2'b00, addr, $urandom, 4'hf);
		cpu_access(2'b00, addr, '0, 4'h0);
		cpu_access(2'b10, {2'b10, rnd[29:2], 2'b00}, $urandom, 4'h3);
		cpu_access(2'b11, {2'b11, rnd[29:2], 2'b00}, $urandom, 4'hf);

		// Random mix, SDRAM left out
		for (int i = 0; i < 200; i++) begin
			rnd = $urandom;
			region = (rnd[1:0] == 2'b01) ? 2'b00 : rnd[1:0];
			addr = {region, rnd[29:2], 2'b00};
			rnd = $urandom;
			cpu_access(region, addr, $urandom, rnd[4] ? rnd[3:0] : 4'h0);
		end

		$display("Checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end
endmodule
